// File: verilog.f
+incdir+verilog
verilog/heapCommandPkg.sv
verilog/heapDataPkg.sv
verilog/heapAllocator.sv
verilog/arraySizeTable.sv
verilog/heapControl.sv
verilog/elementStore.sv
verilog/arrayHeap.sv
verification/clockGen.sv
verification/arrayHeapTb.sv

// File: run.sh
#!/bin/sh
# Build the array heap testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

LOG=simulation.log

verilator --binary --timing --assert -Wno-fatal --top-module arrayHeapTb \
  -f verilog.f --Mdir obj_dir -o arrayHeapSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/arrayHeapSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "No pass message found in $LOG"
  exit 1
fi
exit 0

// File: verification/arrayHeapTb.sv
/*
  Array heap testbench
  Directed and random actions, checked against a reference model of the heap
*/
`timescale 1ns/1ps
`include "heap_config.svh"

module arrayHeapTb
  import heapCommandPkg::*, heapDataPkg::*;
();

  localparam int PERIOD     = 100;       // ns
  localparam int RANDOM_RUN = 300;       // Random actions
  localparam int DIRECTED   = 150;       // Upper bound on directed actions and idle gaps
  localparam int TIMEOUT    = (DIRECTED + RANDOM_RUN + 50) * PERIOD;

  typedef struct packed {
    heapError   err;
    heapElement value;
  } outcome;

  logic       clock, resetN, done;
  heapAction  action;
  heapHandle  array;
  heapIndex   index;
  heapElement in;
  heapResult  out;
  heapError   error;

  clockGen #(.PERIOD(PERIOD), .RESET_CYCLES(4)) clocks (.clock, .resetN);
  arrayHeap uut (.*);

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  logic       modelLive  [`HEAP_ARRAYS];
  heapHandle  modelStack [`HEAP_ARRAYS];   // Freed arrays with the top at modelTop-1
  int         modelSize  [`HEAP_ARRAYS];
  heapElement modelMem   [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  int         modelTop, modelUsed;
  heapElement modelOut;                    // Last accepted result
  outcome     expected [$];                // One entry per action other than nop
  int         checks, failures, testCount, checksBefore, failuresBefore;
  string      testName;
  logic [31:0] lcgState = 32'he04dec82;
  heapAction  codes [22] = '{actNop, actReset, actWrite, actRead, actSize, actInc, actDec,
    actPush, actPop, actAlloc, actFree, actAdd, actAddAfter, actSubtract, actSubAfter,
    actShiftLeft, actShiftRight, actNotLogical, actBitNot, actBitOr, actBitXor, actBitAnd};

  function automatic void clearModel();
    modelTop  = 0;
    modelUsed = 0;
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      modelLive[a] = 1'b0;
      modelSize[a] = 0;
    end
  endfunction

  function automatic outcome predict(input heapAction act, input heapHandle arr,
                                     input heapIndex idx, input heapElement val);
    outcome     result;
    int         sz;
    heapElement old, res;
    heapHandle  h;
    heapError   err;
    logic       arith;
    sz    = modelSize[arr];
    old   = modelMem[arr][idx];
    res   = '0;                            // inc, dec, free and reset
    arith = act inside {[actAdd:actBitAnd]};
    if (!(arith || act inside {[actNop:actDec], actPush, actPop, actAlloc, actFree}))
      err = errBadAction;
    else if (!(act inside {actNop, actReset, actAlloc}) && !modelLive[arr])
      err = errNotLive;
    else if ((act == actRead || arith) && idx >= sz)                  err = errOutOfBounds;
    else if ((act == actPush || act == actInc) && sz == `HEAP_ARRAY_LENGTH) err = errFull;
    else if ((act == actPop || act == actDec) && sz == 0)             err = errEmpty;
    else if (act == actAlloc && modelTop == 0 && modelUsed == `HEAP_ARRAYS)
      err = errOutOfMemory;
    else
      err = errNone;
    if (err == errNone && act != actNop) begin
      case (act)
        actReset: clearModel();
        actWrite: begin
          modelMem[arr][idx] = val;
          if (idx >= sz) modelSize[arr] = idx + 1;   // Write past the end extends
          res = val;
        end
        actRead:  res = old;
        actSize:  res = heapElement'(sz);
        actInc:   modelSize[arr] = sz + 1;
        actDec:   modelSize[arr] = sz - 1;
        actPush: begin
          modelMem[arr][sz] = val;
          modelSize[arr] = sz + 1;
          res = val;
        end
        actPop: begin
          res = modelMem[arr][sz - 1];
          modelSize[arr] = sz - 1;
        end
        actAlloc: begin
          if (modelTop > 0) begin              // Latest freed first
            modelTop = modelTop - 1;
            h = modelStack[modelTop];
          end else begin
            h = heapHandle'(modelUsed);
            modelUsed = modelUsed + 1;
          end
          modelLive[h] = 1'b1;
          modelSize[h] = 0;
          res = heapElement'(h);
        end
        actFree: begin
          modelLive[arr] = 1'b0;
          modelStack[modelTop] = arr;
          modelTop = modelTop + 1;
        end
        actAdd, actAddAfter:      res = old + val;
        actSubtract, actSubAfter: res = old - val;
        actShiftLeft:             res = old << val[3:0];
        actShiftRight:            res = old >> val[3:0];
        actNotLogical:            res = (old == '0) ? heapElement'(1) : '0;
        actBitNot:                res = ~old;
        actBitOr:                 res = old | val;
        actBitXor:                res = old ^ val;
        default:                  res = old & val;
      endcase
      if (arith) modelMem[arr][idx] = res;
      if (act == actAddAfter || act == actSubAfter) res = old;  // Old value forms
      modelOut = res;
    end
    result.err   = err;
    result.value = modelOut;                 // Errors keep the previous out
    return result;
  endfunction

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic issue(input heapAction act, input heapHandle arr, input heapIndex idx,
                       input heapElement val);
    outcome verdict;
    @(posedge clock);
    action <= act;
    array  <= arr;
    index  <= idx;
    in     <= val;
    verdict = predict(act, arr, idx, val);
    if (act != actNop) expected.push_back(verdict);
  endtask

  task automatic startTest(input string name);
    testName       = name;
    checksBefore   = checks;
    failuresBefore = failures;
  endtask

  task automatic finishTest();
    issue(actNop, '0, '0, '0);
    while (expected.size() != 0) @(posedge clock);
    testCount++;
    $display("%s: %0d checks, %0d failures", testName, checks - checksBefore,
             failures - failuresBefore);
  endtask

  // ----------------------------------------
  // Compare at each done
  // ----------------------------------------
  always @(posedge clock) begin
    if (resetN && done) begin
      if (expected.size() == 0) begin
        failures++;
        $display("done pulsed in test %s with no action outstanding", testName);
      end else begin
        checks++;
        if (out !== expected[0].value) begin
          failures++;
          $display("[FAIL] %s out: expected %h, actual %h", testName, expected[0].value, out);
        end
        if (error !== expected[0].err) begin
          failures++;
          $display("[FAIL] %s error: expected %0d, actual %0d", testName, expected[0].err,
                   error);
        end
        void'(expected.pop_front());
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [5:0]  sel;
    heapAction   act;
    action    = actNop;
    array     = '0;
    index     = '0;
    in        = '0;
    checks    = 0;
    failures  = 0;
    testCount = 0;
    modelOut  = '0;
    clearModel();
    wait (resetN === 1'b1);

    startTest("alloc");
    if (out !== '0 || error !== errNone || done !== 1'b0) begin
      failures++;
      $display("Outputs were not cleared by reset");
    end
    issue(actReset, '0, '0, '0);
    repeat (5) issue(actAlloc, '0, '0, '0);         // Handles 0 to 3 and then out of memory
    finishTest();

    startTest("fill");                              // Every element gets a known value
    for (int a = 0; a < `HEAP_ARRAYS; a++)
      for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++)
        issue(actWrite, heapHandle'(a), heapIndex'(i), heapElement'((a * 331 + i * 47) ^ 'h5a3));
    issue(actReset, '0, '0, '0);
    finishTest();

    startTest("reuse");
    repeat (4) issue(actAlloc, '0, '0, '0);
    issue(actFree, 2'd2, '0, '0);
    issue(actFree, 2'd1, '0, '0);
    issue(actRead, 2'd1, '0, '0);                   // Freed arrays are not live
    issue(actWrite, 2'd2, 2'd1, 12'h0aa);
    issue(actFree, 2'd1, '0, '0);
    issue(actAlloc, '0, '0, '0);                    // Array 1 comes back first
    issue(actAlloc, '0, '0, '0);
    issue(actSize, 2'd2, '0, '0);
    issue(actAlloc, '0, '0, '0);
    finishTest();

    startTest("access");
    issue(actRead, 2'd0, 2'd0, '0);                 // Empty array
    issue(actWrite, 2'd0, 2'd2, 12'h5c1);           // Size jumps to 3
    issue(actSize, 2'd0, '0, '0);
    issue(actRead, 2'd0, 2'd2, '0);
    issue(actRead, 2'd0, 2'd3, '0);                 // At size
    issue(actRead, 2'd0, 2'd1, '0);
    issue(actWrite, 2'd0, 2'd3, 12'hfff);
    issue(actSize, 2'd0, '0, '0);
    finishTest();

    startTest("stack");
    issue(actPop, 2'd3, '0, '0);
    issue(actDec, 2'd3, '0, '0);
    for (int k = 0; k < 5; k++) issue(actPush, 2'd3, '0, heapElement'(12'h100 + k * 17));
    issue(actInc, 2'd3, '0, '0);                    // Already full
    for (int k = 0; k < 5; k++) issue(actPop, 2'd3, '0, '0);  // Last in first out
    issue(actInc, 2'd3, '0, '0);
    issue(actInc, 2'd3, '0, '0);
    issue(actDec, 2'd3, '0, '0);
    issue(actSize, 2'd3, '0, '0);
    finishTest();

    startTest("arith");
    issue(actAdd, 2'd1, '0, 12'h001);               // Nothing stored yet
    for (int i = 0; i < 4; i++)
      issue(actWrite, 2'd1, heapIndex'(i), heapElement'(12'h2d0 + i * 12'h111));
    for (int k = 0; k < 11; k++) begin               // add through bitAnd with each read back
      issue(heapAction'(actAdd + k), 2'd1, heapIndex'(k), heapElement'(12'h0a3 + k * 12'h26));
      issue(actRead, 2'd1, heapIndex'(k), '0);
    end
    issue(actNotLogical, 2'd1, 2'd2, '0);           // Element is zero by now
    finishTest();

    startTest("random");
    for (int n = 0; n < RANDOM_RUN; n++) begin
      r   = nextRandom();
      sel = r[31:26];
      if (sel < 44)      act = codes[sel % 22];
      else if (sel < 58) act = actAlloc;            // Keeps arrays live between resets
      else if (sel < 63) act = heapAction'(8'd7 + r[25:24]);  // Unused codes
      else               act = heapAction'(8'hff);
      issue(act, r[23:22], r[21:20], r[19:8]);
    end
    finishTest();

    $display("%0d tests, %0d checks, %0d failures", testCount, checks, failures);
    if (failures == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout: run did not finish within %0d ns", TIMEOUT);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: verification/clockGen.sv
/*
  Clock and reset source for the array heap testbench
*/
`timescale 1ns/1ps

module clockGen #(
  parameter int PERIOD       = 100,      // ns
  parameter int RESET_CYCLES = 4
) (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    resetN = 1'b0;                       // Held low from time zero
    repeat (RESET_CYCLES) @(posedge clock);
    resetN <= 1'b1;                      // Released on a rising edge
  end

endmodule

// File: verilog/arrayHeap.sv
/*
  Array heap
  Top level joining control, allocator, size table and element store
*/
`timescale 1ns/1ps

module arrayHeap
  import heapCommandPkg::*, heapDataPkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  heapAction  action,
  input  heapHandle  array,
  input  heapIndex   index,
  input  heapElement in,
  output heapResult  out,
  output heapError   error,
  output logic       done
);

  // ----------------------------------------
  // Lookups and strobes
  // ----------------------------------------
  logic       live, exhausted;
  heapHandle  granted;
  heapSize    size;
  heapElement oldValue, newValue;
  heapIndex   position;
  logic       allocate, releaseArray, clearAll;
  logic       grow, shrink, extendTo, store;

  heapControl control (
    .clock, .resetN, .action, .array, .index, .in,
    .live, .exhausted, .granted, .size, .oldValue, .newValue,
    .allocate, .releaseArray, .clearAll, .grow, .shrink, .extendTo, .store,
    .position, .out, .error, .done
  );

  heapAllocator allocator (
    .clock, .resetN, .clearAll, .allocate, .releaseArray, .array,
    .live, .granted, .exhausted
  );

  arraySizeTable sizeTable (
    .clock, .resetN, .clearAll, .grow, .shrink, .extendTo,
    .zeroTarget (allocate),               // Granted array starts empty
    .array,
    .target     (granted),
    .index, .size
  );

  elementStore elements (
    .clock, .resetN, .store, .array, .position,
    .operation (action),
    .in, .oldValue, .newValue
  );

endmodule

// File: verilog/elementStore.sv
/*
  Element store
  Element memory of all arrays and the read-modify-write arithmetic
*/
`timescale 1ns/1ps
`include "heap_config.svh"

module elementStore
  import heapCommandPkg::*, heapDataPkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  logic       store,               // Write newValue this edge
  input  heapHandle  array,
  input  heapIndex   position,
  input  heapAction  operation,
  input  heapElement in,
  output heapElement oldValue,            // Element before the update
  output heapElement newValue             // Element after the update
);

  heapElement memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  logic [3:0] shiftAmount;

  assign oldValue    = memory[array][position];
  assign shiftAmount = in[3:0];           // Only the low bits count

  // ----------------------------------------
  // New value per operation
  // ----------------------------------------
  always_comb begin
    case (operation)
      actAdd, actAddAfter:      newValue = oldValue + in;
      actSubtract, actSubAfter: newValue = oldValue - in;
      actShiftLeft:             newValue = oldValue << shiftAmount;
      actShiftRight:            newValue = oldValue >> shiftAmount;
      actNotLogical:            newValue = heapElement'(oldValue == '0);
      actBitNot:                newValue = ~oldValue;
      actBitOr:                 newValue = oldValue | in;
      actBitXor:                newValue = oldValue ^ in;
      actBitAnd:                newValue = oldValue & in;
      default:                  newValue = in;  // Write and push
    endcase
  end

  // Update of the addressed element
  always_ff @(posedge clock) begin
    if (store) memory[array][position] <= newValue;
  end

  // Control only strobes store for actions that write an element
  assert property (@(posedge clock) disable iff (!resetN)
    store |-> operation inside {actWrite, actPush, [actAdd:actBitAnd]});

endmodule

// File: verilog/heapControl.sv
/*
  Heap control
  Decodes each action, checks it, issues the update strobes and registers the result
*/
`timescale 1ns/1ps
`include "heap_config.svh"

module heapControl
  import heapCommandPkg::*, heapDataPkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  heapAction  action,
  input  heapHandle  array,
  input  heapIndex   index,
  input  heapElement in,
  input  logic       live,
  input  logic       exhausted,
  input  heapHandle  granted,
  input  heapSize    size,
  input  heapElement oldValue,
  input  heapElement newValue,
  output logic       allocate,
  output logic       releaseArray,
  output logic       clearAll,
  output logic       grow,
  output logic       shrink,
  output logic       extendTo,
  output logic       store,
  output heapIndex   position,
  output heapResult  out,
  output heapError   error,
  output logic       done
);

  logic      known, needsArray, arithmetic, accepted;
  heapError  nextError;
  heapResult result;

  // ----------------------------------------
  // Decode and error checks
  // ----------------------------------------
  always_comb begin
    known      = 1'b1;
    needsArray = 1'b1;
    arithmetic = 1'b0;
    case (action)
      actNop, actReset, actAlloc: needsArray = 1'b0;  // No array addressed
      actWrite, actRead, actSize, actInc, actDec, actPush, actPop, actFree: known = 1'b1;
      actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft, actShiftRight,
      actNotLogical, actBitNot, actBitOr, actBitXor, actBitAnd: arithmetic = 1'b1;
      default: known = 1'b0;
    endcase
  end

  always_comb begin
    if (!known)                                   nextError = errBadAction;
    else if (needsArray && !live)                 nextError = errNotLive;
    else if ((action == actRead || arithmetic) && heapSize'(index) >= size)
                                                  nextError = errOutOfBounds;
    else if ((action == actPush || action == actInc) && size == `HEAP_ARRAY_LENGTH)
                                                  nextError = errFull;
    else if ((action == actPop || action == actDec) && size == '0)
                                                  nextError = errEmpty;
    else if (action == actAlloc && exhausted)     nextError = errOutOfMemory;
    else                                          nextError = errNone;
  end

  assign accepted     = (nextError == errNone) && (action != actNop);
  assign allocate     = accepted && action == actAlloc;
  assign releaseArray = accepted && action == actFree;
  assign clearAll     = accepted && action == actReset;
  assign grow         = accepted && (action == actPush || action == actInc);
  assign shrink       = accepted && (action == actPop || action == actDec);
  assign extendTo     = accepted && action == actWrite;
  assign store        = accepted && (action == actWrite || action == actPush || arithmetic);

  always_comb begin
    case (action)
      actPush: position = heapIndex'(size);           // First free slot
      actPop:  position = heapIndex'(size - 1'b1);    // Last element
      default: position = index;
    endcase
  end

  // ----------------------------------------
  // Result selection and output register
  // ----------------------------------------
  always_comb begin
    result.element = '0;                              // inc, dec, free, reset
    case (action)
      actWrite, actPush:                         result.element = in;
      actRead, actPop, actAddAfter, actSubAfter: result.element = oldValue;
      actSize:                                   result.element = heapElement'(size);
      actAlloc: begin
        result.allocated.padding = '0;
        result.allocated.handle  = granted;
      end
      default: if (arithmetic) result.element = newValue;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done  <= 1'b0;
      error <= errNone;
      out   <= '0;
    end else begin
      done <= action != actNop;
      if (action != actNop) error <= nextError;
      if (accepted)         out   <= result;      // Errors leave out alone
    end
  end

  assert property (@(posedge clock) disable iff (!resetN) $onehot0({grow, shrink, extendTo}));
  // A freed array reads as not live on the very next action
  assert property (@(posedge clock) disable iff (!resetN)
    releaseArray |=> (array != $past(array) || !live));

endmodule

// File: verilog/arraySizeTable.sv
/*
  Array size table
  Current element count of every array with its update paths
*/
`timescale 1ns/1ps
`include "heap_config.svh"

module arraySizeTable
  import heapDataPkg::*;
(
  input  logic      clock,
  input  logic      resetN,
  input  logic      clearAll,              // Zero every size
  input  logic      grow,                  // Size plus one
  input  logic      shrink,                // Size minus one
  input  logic      extendTo,              // Raise to index plus one
  input  logic      zeroTarget,            // Fresh array from alloc
  input  heapHandle array,
  input  heapHandle target,                // Array being granted
  input  heapIndex  index,
  output heapSize   size
);

  heapSize sizes [`HEAP_ARRAYS];
  heapSize reach;                          // Size implied by a write at index

  assign size  = sizes[array];
  assign reach = heapSize'(index) + 1'b1;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else if (clearAll) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      if (zeroTarget)               sizes[target] <= '0;
      if (grow)                     sizes[array]  <= size + 1'b1;
      if (shrink)                   sizes[array]  <= size - 1'b1;
      if (extendTo && reach > size) sizes[array]  <= reach;  // Never lowers a size
    end
  end

  // ----------------------------------------
  // Full and empty checks upstream keep every count in range
  // ----------------------------------------
  for (genvar g = 0; g < `HEAP_ARRAYS; g++) begin : gSizeCheck
    assert property (@(posedge clock) disable iff (!resetN) sizes[g] <= `HEAP_ARRAY_LENGTH);
  end

endmodule

// File: verilog/heapAllocator.sv
/*
  Heap allocator
  Live flags, a stack of freed arrays and a counter of never-used arrays
*/
`timescale 1ns/1ps
`include "heap_config.svh"

module heapAllocator
  import heapDataPkg::*;
(
  input  logic      clock,
  input  logic      resetN,
  input  logic      clearAll,              // Forget every array
  input  logic      allocate,              // Take the granted array
  input  logic      releaseArray,          // Free the addressed array
  input  heapHandle array,
  output logic      live,                  // Addressed array is in use
  output heapHandle granted,               // Array an alloc would take
  output logic      exhausted              // Nothing left to grant
);

  logic [`HEAP_ARRAYS-1:0]     liveFlags;
  heapHandle                   freeStack [`HEAP_ARRAYS];
  logic [`HEAP_ADDRESS_BITS:0] stackTop;   // Entries on the free stack
  logic [`HEAP_ADDRESS_BITS:0] usedCount;  // Arrays ever handed out
  heapHandle                   topIndex;

  assign topIndex  = heapHandle'(stackTop - 1'b1);
  assign live      = liveFlags[array];
  assign granted   = (stackTop != '0) ? freeStack[topIndex]  // Most recently freed first
                                      : heapHandle'(usedCount);
  assign exhausted = (stackTop == '0) && (usedCount == `HEAP_ARRAYS);

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      liveFlags <= '0;
      stackTop  <= '0;
      usedCount <= '0;
    end else if (clearAll) begin
      liveFlags <= '0;
      stackTop  <= '0;
      usedCount <= '0;
    end else begin
      if (allocate) begin
        liveFlags[granted] <= 1'b1;
        if (stackTop != '0) stackTop <= stackTop - 1'b1;   // Reuse a freed array
        else                usedCount <= usedCount + 1'b1;  // Open a new one
      end
      if (releaseArray) begin
        liveFlags[array] <= 1'b0;
        stackTop         <= stackTop + 1'b1;
      end
    end
  end

  // Free stack entries
  always_ff @(posedge clock) begin
    if (releaseArray && !clearAll) freeStack[heapHandle'(stackTop)] <= array;
  end

  // Each array is freed at most once per life, so the stack never overflows
  assert property (@(posedge clock) disable iff (!resetN) stackTop <= `HEAP_ARRAYS);
  assert property (@(posedge clock) disable iff (!resetN) !(allocate && releaseArray));

endmodule

// File: verilog/heapDataPkg.sv
/*
  Heap data package
  Element, handle, index and size types plus the result word
*/
`include "heap_config.svh"

package heapDataPkg;

  typedef logic [`HEAP_DATA_BITS-1:0]    heapElement;  // One stored word
  typedef logic [`HEAP_ADDRESS_BITS-1:0] heapHandle;   // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]   heapIndex;    // Element number
  typedef logic [`HEAP_INDEX_BITS:0]     heapSize;     // Count up to a full array

  // ----------------------------------------
  // Result word
  // ----------------------------------------
  typedef struct packed {
    logic [`HEAP_DATA_BITS-`HEAP_ADDRESS_BITS-1:0] padding;  // Always zero
    heapHandle                                     handle;   // Granted array
  } heapGrant;

  // Alloc reads out as a handle, all other actions as an element
  typedef union packed {
    heapElement element;
    heapGrant   allocated;
  } heapResult;

endpackage

// File: verilog/heapCommandPkg.sv
/*
  Heap command package
  Action codes accepted by the heap and the error codes it returns
*/
package heapCommandPkg;

  typedef enum logic [7:0] {
    actNop        = 8'd0,               // Idle cycle
    actReset      = 8'd1,               // Forget every array
    actWrite      = 8'd2,               // Write an element
    actRead       = 8'd3,               // Read an element
    actSize       = 8'd4,               // Current size of an array
    actInc        = 8'd5,               // Grow by one
    actDec        = 8'd6,               // Shrink by one
    actPush       = 8'd14,              // Append at the end
    actPop        = 8'd15,              // Remove from the end
    actAlloc      = 8'd18,              // Take a fresh array
    actFree       = 8'd19,              // Hand an array back
    actAdd        = 8'd20,              // Add, new value out
    actAddAfter   = 8'd21,              // Add, old value out
    actSubtract   = 8'd22,              // Subtract, new value out
    actSubAfter   = 8'd23,              // Subtract, old value out
    actShiftLeft  = 8'd24,
    actShiftRight = 8'd25,
    actNotLogical = 8'd26,              // One for zero, else zero
    actBitNot     = 8'd27,
    actBitOr      = 8'd28,
    actBitXor     = 8'd29,
    actBitAnd     = 8'd30
  } heapAction;

  typedef enum logic [2:0] {
    errNone, errNotLive, errOutOfBounds, errFull, errEmpty, errOutOfMemory, errBadAction
  } heapError;

endpackage

// File: verilog/heap_config.svh
/*
  Heap configuration
  Widths of handles, indices and elements, and the counts derived from them
*/
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// ----------------------------------------
// Base widths
// ----------------------------------------
`define HEAP_ADDRESS_BITS 2                     // Bits in an array number
`define HEAP_INDEX_BITS   2                     // Bits in an element index
`define HEAP_DATA_BITS    12                    // Bits in an element

// ----------------------------------------
// Derived counts
// ----------------------------------------
`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)  // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)    // Elements per array

`endif
